//--- common/agen_cfg.svh
`ifndef AGEN_CFG_SVH
`define AGEN_CFG_SVH

// data memory and address generator widths
`define AGEN_ADDR_W       10
`define AGEN_PERIOD_W     10
`define AGEN_DATA_W       32

// wishbone word address, bit 11 selects the data memory
`define AGEN_BUS_ADDR_W   12
`define AGEN_MEM_SEL      11

// unused upper bits of the loop configuration words
`define AGEN_COUNT_PAD_W  (`AGEN_DATA_W - `AGEN_ADDR_W - `AGEN_PERIOD_W)
`define AGEN_STEP_PAD_W   (`AGEN_DATA_W - 2 * `AGEN_ADDR_W)

// second field of the start and timing words starts here
`define AGEN_HI_LSB       16

// register map, word offsets
`define AGEN_REG_COUNT    4'd0
`define AGEN_REG_SRC_STEP 4'd3
`define AGEN_REG_DST_STEP 4'd6
`define AGEN_REG_START    4'd9
`define AGEN_REG_TIMING   4'd10
`define AGEN_REG_CTRL     4'd11

`endif

//--- common/agenPkg.sv
`include "agen_cfg.svh"

package agenPkg;

   // wishbone classic, host to slave
   typedef struct packed {
      logic                        cyc;
      logic                        stb;
      logic                        we;
      logic [`AGEN_BUS_ADDR_W-1:0] adr;
      logic [`AGEN_DATA_W-1:0]     dat;
   } wbReqT;

   typedef struct packed {
      logic                    ack;
      logic [`AGEN_DATA_W-1:0] dat;
   } wbRspT;

   // iterations in the low bits, period above
   typedef struct packed {
      logic [`AGEN_COUNT_PAD_W-1:0] pad;
      logic [`AGEN_PERIOD_W-1:0]    period;
      logic [`AGEN_ADDR_W-1:0]      iterations;
   } loopCountT;

   typedef struct packed {
      logic [`AGEN_STEP_PAD_W-1:0] pad;
      logic signed [`AGEN_ADDR_W-1:0] shift;
      logic signed [`AGEN_ADDR_W-1:0] incr;
   } loopStepT;

   // same bus word, meaning depends on the register offset
   typedef union packed {
      loopCountT count;
      loopStepT  step;
   } loopWordU;

   // shared by source and destination streams, lvl[0] is innermost
   typedef struct packed {
      logic [`AGEN_PERIOD_W-1:0] duty;
      logic [`AGEN_PERIOD_W-1:0] delay;
      loopCountT [2:0]           lvl;
   } timingCfgT;

   typedef struct packed {
      logic [`AGEN_ADDR_W-1:0] start;
      loopStepT [2:0]          lvl;
   } streamCfgT;

   typedef struct packed {
      logic [`AGEN_ADDR_W-1:0] addr;
      logic                    en;
   } memCmdT;

endpackage

//--- rtl/wbCfgRegs.sv
`timescale 1ns/10ps
`include "agen_cfg.svh"

module wbCfgRegs (
   input  logic                    clk,
   input  logic                    rst,
   input  agenPkg::wbReqT          wbReq,
   output agenPkg::wbRspT          wbRsp,
   output agenPkg::timingCfgT      timing,
   output agenPkg::streamCfgT      srcCfg,
   output agenPkg::streamCfgT      dstCfg,
   output logic                    start,
   output logic [`AGEN_ADDR_W-1:0] hostAddr,
   output logic                    hostWe,
   output logic                    hostRe,
   output logic [`AGEN_DATA_W-1:0] hostWdata,
   input  logic [`AGEN_DATA_W-1:0] hostRdata,
   input  logic                    busy
);

   agenPkg::loopWordU [2:0] countWord;
   agenPkg::loopWordU [2:0] srcStepWord;
   agenPkg::loopWordU [2:0] dstStepWord;
   logic [`AGEN_DATA_W-1:0] startWord;
   logic [`AGEN_DATA_W-1:0] timingWord;
   logic [`AGEN_DATA_W-1:0] regRdata;
   logic [`AGEN_DATA_W-1:0] rspData;
   logic [3:0]              regOff;
   logic                    ackReg;
   logic                    rdWait;
   logic                    access;
   logic                    isMem;
   logic                    cfgWr;

   assign isMem  = wbReq.adr[`AGEN_MEM_SEL];
   assign regOff = wbReq.adr[3:0];
   // one access per strobe, none while an ack or a memory read is pending
   assign access = wbReq.cyc & wbReq.stb & ~ackReg & ~rdWait;
   assign cfgWr  = access & ~isMem & wbReq.we & ~busy;

   assign hostAddr  = wbReq.adr[`AGEN_ADDR_W-1:0];
   assign hostWdata = wbReq.dat;
   assign hostWe    = access & isMem & wbReq.we;
   assign hostRe    = access & isMem & ~wbReq.we;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         countWord   <= '0;
         srcStepWord <= '0;
         dstStepWord <= '0;
         startWord   <= '0;
         timingWord  <= '0;
      end else if (cfgWr) begin
         for (int i = 0; i < 3; i++) begin
            if (regOff == `AGEN_REG_COUNT + i)
               countWord[i] <= wbReq.dat;
            if (regOff == `AGEN_REG_SRC_STEP + i)
               srcStepWord[i] <= wbReq.dat;
            if (regOff == `AGEN_REG_DST_STEP + i)
               dstStepWord[i] <= wbReq.dat;
         end
         if (regOff == `AGEN_REG_START)
            startWord <= wbReq.dat;
         if (regOff == `AGEN_REG_TIMING)
            timingWord <= wbReq.dat;
      end
   end

   // memory reads take one extra cycle for the registered RAM output
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ackReg <= 1'b0;
         rdWait <= 1'b0;
         start  <= 1'b0;
      end else begin
         ackReg <= (access & ~hostRe) | rdWait;
         rdWait <= hostRe;
         start  <= cfgWr & (regOff == `AGEN_REG_CTRL) & wbReq.dat[0];
      end
   end

   always_ff @(posedge clk) begin
      if (rdWait)
         rspData <= hostRdata;
      else if (access)
         rspData <= regRdata;
   end

   always_comb begin
      regRdata = '0;
      for (int i = 0; i < 3; i++) begin
         if (regOff == `AGEN_REG_COUNT + i)
            regRdata = countWord[i];
         if (regOff == `AGEN_REG_SRC_STEP + i)
            regRdata = srcStepWord[i];
         if (regOff == `AGEN_REG_DST_STEP + i)
            regRdata = dstStepWord[i];
      end
      case (regOff)
         `AGEN_REG_START:  regRdata = startWord;
         `AGEN_REG_TIMING: regRdata = timingWord;
         `AGEN_REG_CTRL:   regRdata = {{(`AGEN_DATA_W - 1){1'b0}}, busy};
         default: ;
      endcase
   end

   // unpack the stored words into the generator settings
   always_comb begin
      timing.duty   = timingWord[`AGEN_PERIOD_W-1:0];
      timing.delay  = timingWord[`AGEN_HI_LSB +: `AGEN_PERIOD_W];
      srcCfg.start  = startWord[`AGEN_ADDR_W-1:0];
      dstCfg.start  = startWord[`AGEN_HI_LSB +: `AGEN_ADDR_W];
      for (int i = 0; i < 3; i++) begin
         timing.lvl[i] = countWord[i].count;
         srcCfg.lvl[i] = srcStepWord[i].step;
         dstCfg.lvl[i] = dstStepWord[i].step;
      end
   end

   always_comb begin
      wbRsp.ack = ackReg;
      wbRsp.dat = rspData;
   end

   ackOneCycle: assert property (@(posedge clk) disable iff (rst) ackReg |=> !ackReg);

endmodule

//--- addrGen/addrGen.sv
`timescale 1ns/10ps
`include "agen_cfg.svh"

// two nested loops: incr inside a period, shift at each period wrap
module addrGen (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           init,
   input  logic                           run,
   input  logic                           pause,
   input  logic [`AGEN_ADDR_W-1:0]        iterations,
   input  logic [`AGEN_PERIOD_W-1:0]      period,
   input  logic [`AGEN_PERIOD_W-1:0]      duty,
   input  logic [`AGEN_PERIOD_W-1:0]      delay,
   input  logic [`AGEN_ADDR_W-1:0]        start,
   input  logic signed [`AGEN_ADDR_W-1:0] shift,
   input  logic signed [`AGEN_ADDR_W-1:0] incr,
   output logic [`AGEN_ADDR_W-1:0]        addr,
   output logic                           en,
   output logic                           done
);

   logic [`AGEN_PERIOD_W-1:0] perCnt;
   logic [`AGEN_PERIOD_W-1:0] delayCnt;
   logic [`AGEN_ADDR_W-1:0]   iterCnt;
   logic                      active;
   logic                      advance;
   logic                      lastPer;
   logic                      lastIter;

   // extra bit so a count at its maximum does not wrap in the compare
   assign lastPer  = ({1'b0, perCnt} + 1'b1) >= {1'b0, period};
   assign lastIter = ({1'b0, iterCnt} + 1'b1) >= {1'b0, iterations};

   // counters move only once the start delay has run out
   assign advance = active & ~init & ~pause & (delayCnt == '0);
   // duty cycles at the start of each period are enabled
   assign en      = advance & (perCnt < duty);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         addr     <= '0;
         perCnt   <= '0;
         iterCnt  <= '0;
         delayCnt <= '0;
         active   <= 1'b0;
         done     <= 1'b0;
      end else if (init) begin
         addr     <= start;
         perCnt   <= '0;
         iterCnt  <= '0;
         delayCnt <= delay;
         active   <= run;
         done     <= 1'b0;
      end else if (active & ~pause) begin
         if (delayCnt != '0) begin
            delayCnt <= delayCnt - 1'b1;
         end else if (lastPer) begin
            // shift replaces incr on the last cycle of a period
            perCnt <= '0;
            addr   <= addr + shift;
            if (lastIter) begin
               iterCnt <= '0;
               active  <= 1'b0;
               done    <= 1'b1;
            end else begin
               iterCnt <= iterCnt + 1'b1;
            end
         end else begin
            perCnt <= perCnt + 1'b1;
            addr   <= addr + incr;
         end
      end
   end

endmodule

//--- addrGen/addrGen3.sv
`timescale 1ns/10ps
`include "agen_cfg.svh"

// six loops: levelA inner, levelB middle, levelC outer
module addrGen3 (
   input  logic                clk,
   input  logic                rst,
   input  logic                run,
   input  agenPkg::timingCfgT  timing,
   input  agenPkg::streamCfgT  cfg,
   output agenPkg::memCmdT     cmd,
   output logic                done
);

   logic [`AGEN_ADDR_W-1:0]   addrA;
   logic [`AGEN_ADDR_W-1:0]   addrB;
   logic [`AGEN_ADDR_W-1:0]   addrC;
   logic [`AGEN_ADDR_W-1:0]   startA;
   logic [`AGEN_ADDR_W-1:0]   startB;
   logic [`AGEN_PERIOD_W-1:0] delayA;
   logic enA;
   logic enB;
   logic enC;
   logic doneA;
   logic doneB;
   logic doneC;
   logic finA;
   logic finB;
   logic finC;
   logic enBReg;
   logic enCReg;
   logic relaunchB;
   logic relaunchBReg;
   logic launchA;
   logic launchB;
   logic pauseB;
   logic pauseC;

   // a level with zero iterations is skipped and counts as finished
   assign finA = doneA | ~(|timing.lvl[0].iterations);
   assign finB = doneB | ~(|timing.lvl[1].iterations);
   assign finC = doneC | ~(|timing.lvl[2].iterations);
   assign done = finA & finB & finC;

   // an outer step restarts the level below from the new address
   assign relaunchB = enCReg & ~doneC;
   assign launchB   = run | relaunchB;
   assign launchA   = run | (enBReg & ~doneB) | relaunchBReg;

   // outer levels take one step each time everything below has finished
   assign pauseB = ~finA | launchA;
   assign pauseC = ~finA | ~finB | launchA | launchB;

   assign startA = run ? cfg.start : addrB;
   assign startB = run ? cfg.start : addrC;
   // start delay only before the very first pass
   assign delayA = run ? timing.delay : '0;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         enBReg       <= 1'b0;
         enCReg       <= 1'b0;
         relaunchBReg <= 1'b0;
      end else begin
         enBReg       <= enB;
         enCReg       <= enC;
         relaunchBReg <= relaunchB;
      end
   end

   addrGen levelA (
      .clk(clk), .rst(rst), .init(launchA), .run(launchA), .pause(1'b0),
      .iterations(timing.lvl[0].iterations), .period(timing.lvl[0].period),
      .duty(timing.duty), .delay(delayA), .start(startA),
      .shift(cfg.lvl[0].shift), .incr(cfg.lvl[0].incr),
      .addr(addrA), .en(enA), .done(doneA)
   );

   addrGen levelB (
      .clk(clk), .rst(rst), .init(launchB), .run(launchB), .pause(pauseB),
      .iterations(timing.lvl[1].iterations), .period(timing.lvl[1].period),
      .duty(timing.lvl[1].period), .delay({`AGEN_PERIOD_W{1'b0}}), .start(startB),
      .shift(cfg.lvl[1].shift), .incr(cfg.lvl[1].incr),
      .addr(addrB), .en(enB), .done(doneB)
   );

   addrGen levelC (
      .clk(clk), .rst(rst), .init(run), .run(run), .pause(pauseC),
      .iterations(timing.lvl[2].iterations), .period(timing.lvl[2].period),
      .duty(timing.lvl[2].period), .delay({`AGEN_PERIOD_W{1'b0}}), .start(cfg.start),
      .shift(cfg.lvl[2].shift), .incr(cfg.lvl[2].incr),
      .addr(addrC), .en(enC), .done(doneC)
   );

   always_comb begin
      cmd.addr = addrA;
      cmd.en   = enA;
   end

endmodule

//--- rtl/memCopyEngine.sv
`timescale 1ns/10ps
`include "agen_cfg.svh"

module memCopyEngine (
   input  logic                    clk,
   input  logic                    rst,
   input  agenPkg::memCmdT         srcCmd,
   input  agenPkg::memCmdT         dstCmd,
   input  logic                    srcDone,
   input  logic                    dstDone,
   input  logic                    start,
   input  logic [`AGEN_ADDR_W-1:0] hostAddr,
   input  logic                    hostWe,
   input  logic                    hostRe,
   input  logic [`AGEN_DATA_W-1:0] hostWdata,
   output logic [`AGEN_DATA_W-1:0] hostRdata,
   output logic                    busy
);

   logic [`AGEN_DATA_W-1:0] mem [0:(1 << `AGEN_ADDR_W) - 1];
   logic [`AGEN_DATA_W-1:0] rdData;
   logic [`AGEN_DATA_W-1:0] wrData;
   logic [`AGEN_ADDR_W-1:0] rdAddr;
   logic [`AGEN_ADDR_W-1:0] wrAddr;
   logic [`AGEN_ADDR_W-1:0] dstAddrReg;
   logic                    rdEn;
   logic                    wrEn;
   logic                    wrPend;
   logic                    hostRdReg;

   // copy owns both ports while busy, the host gets them when idle
   assign rdAddr = busy ? srcCmd.addr : hostAddr;
   assign rdEn   = busy ? srcCmd.en : hostRe;
   assign wrEn   = wrPend | (hostWe & ~busy);
   assign wrAddr = wrPend ? dstAddrReg : hostAddr;
   assign wrData = wrPend ? rdData : hostWdata;

   always_ff @(posedge clk) begin
      if (rdEn)
         rdData <= mem[rdAddr];
      if (wrEn)
         mem[wrAddr] <= wrData;
   end

   // destination lags by one cycle to meet the read data
   always_ff @(posedge clk) begin
      dstAddrReg <= dstCmd.addr;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy      <= 1'b0;
         wrPend    <= 1'b0;
         hostRdReg <= 1'b0;
      end else begin
         wrPend    <= busy & dstCmd.en;
         hostRdReg <= hostRe & ~busy;
         if (start)
            busy <= 1'b1;
         else if (busy & srcDone & dstDone & ~wrPend)
            busy <= 1'b0;
      end
   end

   // host reads during a copy return zero
   assign hostRdata = hostRdReg ? rdData : '0;

   // both generators share timing, so their enables must line up
   enLockstep: assert property (@(posedge clk) disable iff (rst)
      busy |-> (srcCmd.en == dstCmd.en));

endmodule

//--- rtl/stridedCopyTop.sv
`timescale 1ns/10ps
`include "agen_cfg.svh"

module stridedCopyTop (
   input  logic           clk,
   input  logic           rst,
   input  agenPkg::wbReqT wbReq,
   output agenPkg::wbRspT wbRsp
);

   agenPkg::timingCfgT      timing;
   agenPkg::streamCfgT      srcCfg;
   agenPkg::streamCfgT      dstCfg;
   agenPkg::memCmdT         srcCmd;
   agenPkg::memCmdT         dstCmd;
   logic [`AGEN_ADDR_W-1:0] hostAddr;
   logic [`AGEN_DATA_W-1:0] hostWdata;
   logic [`AGEN_DATA_W-1:0] hostRdata;
   logic                    hostWe;
   logic                    hostRe;
   logic                    start;
   logic                    busy;
   logic                    srcDone;
   logic                    dstDone;

   wbCfgRegs regs (
      .clk(clk), .rst(rst), .wbReq(wbReq), .wbRsp(wbRsp),
      .timing(timing), .srcCfg(srcCfg), .dstCfg(dstCfg), .start(start),
      .hostAddr(hostAddr), .hostWe(hostWe), .hostRe(hostRe),
      .hostWdata(hostWdata), .hostRdata(hostRdata), .busy(busy)
   );

   // read and write address streams, started together
   addrGen3 srcGen (
      .clk(clk), .rst(rst), .run(start), .timing(timing), .cfg(srcCfg),
      .cmd(srcCmd), .done(srcDone)
   );

   addrGen3 dstGen (
      .clk(clk), .rst(rst), .run(start), .timing(timing), .cfg(dstCfg),
      .cmd(dstCmd), .done(dstDone)
   );

   memCopyEngine engine (
      .clk(clk), .rst(rst), .srcCmd(srcCmd), .dstCmd(dstCmd),
      .srcDone(srcDone), .dstDone(dstDone), .start(start),
      .hostAddr(hostAddr), .hostWe(hostWe), .hostRe(hostRe),
      .hostWdata(hostWdata), .hostRdata(hostRdata), .busy(busy)
   );

endmodule

//--- sim/tbStridedCopy.sv
`timescale 1ns/10ps
`include "agen_cfg.svh"

module tbStridedCopy;

   localparam int memWords  = 1 << `AGEN_ADDR_W;
   localparam int ackLimit  = 8;
   localparam int pollLimit = 400;
   localparam int busCycles = ackLimit + 2;
   // four full fills and four full readbacks dominate, then four polled copies
   localparam int watchdogCycles =
      (8 * memWords + 200) * busCycles + 4 * pollLimit * busCycles + 16;

   logic                    clk;
   logic                    rst;
   agenPkg::wbReqT          wbReq;
   agenPkg::wbRspT          wbRsp;
   logic [`AGEN_DATA_W-1:0] memModel [0:memWords-1];
   logic [`AGEN_ADDR_W-1:0] addrSeq[$];
   agenPkg::timingCfgT      curTiming;
   agenPkg::streamCfgT      curSrc;
   agenPkg::streamCfgT      curDst;
   string                   curTest;
   int                      errorCount;
   int                      testErrors;
   int                      checkCount;
   int                      testsRun;
   int                      testsFailed;
   int                      seed;

   stridedCopyTop dut (.clk(clk), .rst(rst), .wbReq(wbReq), .wbRsp(wbRsp));

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      repeat (watchdogCycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, the DUT stopped responding", watchdogCycles);
      $display("Verification failed");
      $finish;
   end

   function automatic logic [`AGEN_BUS_ADDR_W-1:0] regAdr(input int off);
      logic [`AGEN_BUS_ADDR_W-1:0] a;
      a = '0;
      a[3:0] = off[3:0];
      return a;
   endfunction

   function automatic logic [`AGEN_BUS_ADDR_W-1:0] memAdr(input int addr);
      logic [`AGEN_BUS_ADDR_W-1:0] a;
      a = '0;
      a[`AGEN_MEM_SEL] = 1'b1;
      a[`AGEN_ADDR_W-1:0] = addr[`AGEN_ADDR_W-1:0];
      return a;
   endfunction

   function automatic agenPkg::loopCountT makeCount(input int iters, input int period);
      agenPkg::loopCountT c;
      c = '0;
      c.iterations = iters[`AGEN_ADDR_W-1:0];
      c.period     = period[`AGEN_PERIOD_W-1:0];
      return c;
   endfunction

   function automatic agenPkg::loopStepT makeStep(input int incr, input int shift);
      agenPkg::loopStepT s;
      s = '0;
      s.incr  = incr[`AGEN_ADDR_W-1:0];
      s.shift = shift[`AGEN_ADDR_W-1:0];
      return s;
   endfunction

   function automatic int periodOf(input agenPkg::loopCountT c);
      return (c.period == 0) ? 1 : int'(c.period);
   endfunction

   // a level with zero iterations gives one pass and never steps
   function automatic int levelPasses(input agenPkg::loopCountT c);
      if (c.iterations == 0)
         return 1;
      return int'(c.iterations) * periodOf(c);
   endfunction

   // shift on the last step of a period, incr on all others
   function automatic logic [`AGEN_ADDR_W-1:0] stepOf(input agenPkg::loopCountT c,
                                                      input agenPkg::loopStepT s, input int m);
      if (m % periodOf(c) == periodOf(c) - 1)
         return s.shift;
      return s.incr;
   endfunction

   task automatic noteError();
      errorCount++;
      testErrors++;
   endtask

   task automatic startTest(input string name);
      curTest    = name;
      testErrors = 0;
   endtask

   task automatic finishTest();
      testsRun++;
      if (testErrors != 0) begin
         testsFailed++;
         $display("test %s failed, %0d errors", curTest, testErrors);
      end else begin
         $display("test %s passed", curTest);
      end
   endtask

   task automatic checkRsp(input string what, input logic [`AGEN_DATA_W-1:0] exp,
                           input logic [`AGEN_DATA_W-1:0] act);
      checkCount++;
      if (act !== exp) begin
         $display("error %s: %s expected %h actual %h", curTest, what, exp, act);
         noteError();
      end
   endtask

   task automatic checkLoop(input string what, input bit isStep,
                            input agenPkg::loopWordU exp, input agenPkg::loopWordU act);
      checkCount++;
      if (act !== exp) begin
         if (isStep)
            $display("error %s: %s expected incr %0d shift %0d actual incr %0d shift %0d",
                     curTest, what, exp.step.incr, exp.step.shift,
                     act.step.incr, act.step.shift);
         else
            $display("error %s: %s expected iterations %0d period %0d actual %0d %0d",
                     curTest, what, exp.count.iterations, exp.count.period,
                     act.count.iterations, act.count.period);
         noteError();
      end
   endtask

   // one classic cycle, strobe held until ack
   // latency counts cycles from the edge that first sees the strobe
   task automatic busCycle(input logic we, input logic [`AGEN_BUS_ADDR_W-1:0] adr,
                           input logic [`AGEN_DATA_W-1:0] dat, input int latency,
                           output agenPkg::wbRspT rsp);
      int waitCnt;
      waitCnt = 0;
      rsp = '0;
      @(posedge clk);
      wbReq.cyc <= 1'b1;
      wbReq.stb <= 1'b1;
      wbReq.we  <= we;
      wbReq.adr <= adr;
      wbReq.dat <= dat;
      do begin
         @(negedge clk);
         waitCnt++;
      end while (!wbRsp.ack && waitCnt < ackLimit);
      if (wbRsp.ack) begin
         rsp = wbRsp;
         checkCount++;
         if (waitCnt != latency + 1) begin
            $display("error %s: ack latency at %h expected %0d actual %0d",
                     curTest, adr, latency, waitCnt - 1);
            noteError();
         end
      end else begin
         $display("no acknowledge within %0d cycles for bus address %h", ackLimit, adr);
         noteError();
      end
      @(posedge clk);
      wbReq.cyc <= 1'b0;
      wbReq.stb <= 1'b0;
      wbReq.we  <= 1'b0;
   endtask

   task automatic wbWrite(input logic [`AGEN_BUS_ADDR_W-1:0] adr,
                          input logic [`AGEN_DATA_W-1:0] dat);
      agenPkg::wbRspT rsp;
      busCycle(1'b1, adr, dat, 1, rsp);
   endtask

   task automatic wbRead(input logic [`AGEN_BUS_ADDR_W-1:0] adr,
                         output logic [`AGEN_DATA_W-1:0] dat);
      agenPkg::wbRspT rsp;
      busCycle(1'b0, adr, '0, adr[`AGEN_MEM_SEL] ? 2 : 1, rsp);
      dat = rsp.dat;
   endtask

   task automatic pollBusy();
      logic [`AGEN_DATA_W-1:0] d;
      int polls;
      polls = 0;
      do begin
         wbRead(regAdr(`AGEN_REG_CTRL), d);
         polls++;
      end while (d[0] && polls < pollLimit);
      if (d[0]) begin
         $display("busy still set after %0d polls of the control register", polls);
         noteError();
      end
   endtask

   task automatic fillMemory();
      logic [`AGEN_DATA_W-1:0] d;
      for (int i = 0; i < memWords; i++) begin
         d = $urandom;
         wbWrite(memAdr(i), d);
         memModel[i] = d;
      end
   endtask

   task automatic checkMemory();
      logic [`AGEN_DATA_W-1:0] d;
      for (int i = 0; i < memWords; i++) begin
         wbRead(memAdr(i), d);
         checkRsp($sformatf("word %0d", i), memModel[i], d);
      end
   endtask

   task automatic configure(input agenPkg::timingCfgT t, input agenPkg::streamCfgT src,
                            input agenPkg::streamCfgT dst);
      logic [`AGEN_DATA_W-1:0] w;
      for (int i = 0; i < 3; i++) begin
         wbWrite(regAdr(`AGEN_REG_COUNT + i), t.lvl[i]);
         wbWrite(regAdr(`AGEN_REG_SRC_STEP + i), src.lvl[i]);
         wbWrite(regAdr(`AGEN_REG_DST_STEP + i), dst.lvl[i]);
      end
      w = '0;
      w[`AGEN_ADDR_W-1:0] = src.start;
      w[`AGEN_HI_LSB +: `AGEN_ADDR_W] = dst.start;
      wbWrite(regAdr(`AGEN_REG_START), w);
      w = '0;
      w[`AGEN_PERIOD_W-1:0] = t.duty;
      w[`AGEN_HI_LSB +: `AGEN_PERIOD_W] = t.delay;
      wbWrite(regAdr(`AGEN_REG_TIMING), w);
      curTiming = t;
      curSrc    = src;
      curDst    = dst;
   endtask

   // six nested loops, each outer pass restarts the inner level at its own address
   task automatic buildSeq(input agenPkg::timingCfgT t, input agenPkg::streamCfgT s);
      logic [`AGEN_ADDR_W-1:0] aAddr;
      logic [`AGEN_ADDR_W-1:0] bAddr;
      logic [`AGEN_ADDR_W-1:0] cAddr;
      addrSeq.delete();
      cAddr = s.start;
      for (int mc = 0; mc < levelPasses(t.lvl[2]); mc++) begin
         bAddr = cAddr;
         for (int mb = 0; mb < levelPasses(t.lvl[1]); mb++) begin
            aAddr = bAddr;
            for (int ia = 0; ia < int'(t.lvl[0].iterations); ia++) begin
               for (int p = 0; p < periodOf(t.lvl[0]); p++) begin
                  if (p < int'(t.duty))
                     addrSeq.push_back(aAddr);
                  aAddr = aAddr + stepOf(t.lvl[0], s.lvl[0], p);
               end
            end
            bAddr = bAddr + stepOf(t.lvl[1], s.lvl[1], mb);
         end
         cAddr = cAddr + stepOf(t.lvl[2], s.lvl[2], mc);
      end
   endtask

   // k-th destination gets the word at the k-th source
   task automatic applyCopy();
      logic [`AGEN_ADDR_W-1:0] srcList[$];
      buildSeq(curTiming, curSrc);
      srcList = addrSeq;
      buildSeq(curTiming, curDst);
      for (int k = 0; k < addrSeq.size(); k++)
         memModel[addrSeq[k]] = memModel[srcList[k]];
   endtask

   task automatic testRegisters();
      agenPkg::loopWordU       expCount;
      agenPkg::loopWordU       expStep;
      agenPkg::loopWordU       act;
      logic [`AGEN_DATA_W-1:0] d;
      startTest("register readback");
      wbRead(regAdr(`AGEN_REG_CTRL), d);
      checkRsp("control after reset", '0, d);
      expCount.count = makeCount(7, 5);
      expStep.step   = makeStep(-3, -17);
      wbWrite(regAdr(`AGEN_REG_COUNT + 1), expCount);
      wbWrite(regAdr(`AGEN_REG_DST_STEP + 2), expStep);
      wbRead(regAdr(`AGEN_REG_COUNT + 1), d);
      act = d;
      checkLoop("level 2 count word", 1'b0, expCount, act);
      wbRead(regAdr(`AGEN_REG_DST_STEP + 2), d);
      act = d;
      checkLoop("level 3 destination step", 1'b1, expStep, act);
      finishTest();
   endtask

   task automatic testHostMemory();
      logic [`AGEN_DATA_W-1:0] d;
      startTest("host memory access");
      for (int i = 0; i < 16; i++) begin
         d = $urandom;
         wbWrite(memAdr(i * 61 + 7), d);
         memModel[i * 61 + 7] = d;
      end
      for (int i = 0; i < 16; i++) begin
         wbRead(memAdr(i * 61 + 7), d);
         checkRsp($sformatf("word %0d", i * 61 + 7), memModel[i * 61 + 7], d);
      end
      finishTest();
   endtask

   task automatic testContiguous();
      agenPkg::timingCfgT t;
      agenPkg::streamCfgT src;
      agenPkg::streamCfgT dst;
      startTest("contiguous copy");
      fillMemory();
      t = '0;
      t.duty   = 10'd1023;
      t.lvl[0] = makeCount(8, 1);
      src = '0;
      src.lvl[0] = makeStep(1, 1);
      dst = src;
      dst.start = 10'd100;
      configure(t, src, dst);
      wbWrite(regAdr(`AGEN_REG_CTRL), 32'h1);
      pollBusy();
      applyCopy();
      checkMemory();
      finishTest();
   endtask

   // levels differ in every step, duty drops one cycle of four
   task automatic setupGather();
      agenPkg::timingCfgT t;
      agenPkg::streamCfgT src;
      agenPkg::streamCfgT dst;
      t.duty   = 10'd3;
      t.delay  = 10'd5;
      t.lvl[0] = makeCount(3, 4);
      t.lvl[1] = makeCount(2, 2);
      t.lvl[2] = makeCount(2, 1);
      src.start  = 10'd16;
      src.lvl[0] = makeStep(1, 2);
      src.lvl[1] = makeStep(20, 30);
      src.lvl[2] = makeStep(0, 100);
      dst.start  = 10'd512;
      dst.lvl[0] = makeStep(2, -3);
      dst.lvl[1] = makeStep(40, -15);
      dst.lvl[2] = makeStep(0, 200);
      configure(t, src, dst);
   endtask

   task automatic testGather();
      startTest("strided gather");
      fillMemory();
      setupGather();
      wbWrite(regAdr(`AGEN_REG_CTRL), 32'h1);
      pollBusy();
      applyCopy();
      checkMemory();
      finishTest();
   endtask

   task automatic testBusyProtect();
      logic [`AGEN_DATA_W-1:0] d;
      startTest("busy protection");
      fillMemory();
      wbWrite(regAdr(`AGEN_REG_CTRL), 32'h1);
      wbRead(regAdr(`AGEN_REG_CTRL), d);
      checkRsp("control during copy", 32'h1, d);
      // word 1000 lies outside both streams
      wbWrite(memAdr(1000), ~memModel[1000]);
      wbRead(memAdr(1000), d);
      checkRsp("memory read during copy", '0, d);
      // a live step change would move the destination stream
      wbWrite(regAdr(`AGEN_REG_DST_STEP), makeStep(5, 7));
      wbWrite(regAdr(`AGEN_REG_CTRL), 32'h1);
      pollBusy();
      applyCopy();
      checkMemory();
      finishTest();
   endtask

   task automatic testZeroLevels();
      agenPkg::timingCfgT t;
      agenPkg::streamCfgT src;
      agenPkg::streamCfgT dst;
      startTest("zero-iteration outer levels");
      fillMemory();
      t = '0;
      t.duty   = 10'd1023;
      t.delay  = 10'd2;
      t.lvl[0] = makeCount(5, 2);
      src.start  = 10'd300;
      src.lvl[0] = makeStep(3, 1);
      src.lvl[1] = makeStep(7, 9);
      src.lvl[2] = makeStep(11, 13);
      dst.start  = 10'd600;
      dst.lvl[0] = makeStep(-2, 5);
      dst.lvl[1] = makeStep(17, 19);
      dst.lvl[2] = makeStep(23, 29);
      configure(t, src, dst);
      wbWrite(regAdr(`AGEN_REG_CTRL), 32'h1);
      pollBusy();
      applyCopy();
      checkMemory();
      finishTest();
   endtask

   initial begin
      seed        = $urandom(30337);
      errorCount  = 0;
      testErrors  = 0;
      checkCount  = 0;
      testsRun    = 0;
      testsFailed = 0;
      wbReq       = '0;
      rst         = 1'b1;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      testRegisters();
      testHostMemory();
      testContiguous();
      testGather();
      testBusyProtect();
      testZeroLevels();
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               testsRun, testsFailed, checkCount, errorCount);
      if (errorCount == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

//--- flist.f
+incdir+common
common/agenPkg.sv
rtl/wbCfgRegs.sv
addrGen/addrGen.sv
addrGen/addrGen3.sv
rtl/memCopyEngine.sv
rtl/stridedCopyTop.sv
sim/tbStridedCopy.sv
